// ==== verilog.f ====
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_execute_stage.sv
hdl/exu_data_ram.sv
hdl/exu_mem_stage.sv
hdl/exu_top.sv
verification/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the execute subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module exu_tb -o exu_sim

# keep the output so the result can be searched without a log file
out=$(./obj_dir/exu_sim 2>&1) || true
echo "$out"

echo "$out" | grep -qx "STATUS: PASS"

// ==== verification/exu_patterns.hex ====
// ctrl pc src1 src2 rk_data br_offs pred_target exp_target exp_ctl exp_wdata
// ctrl: tbflags alu_op br_kind jirl/pred size store/signed/gr_we dest; exp_ctl: ecode ex gr_we dest
00000401 1c000000 00001234 00000fff 00000000 00000000 00000000 00000000 00000101 00002233
01000402 1c000004 00000005 00000007 00000000 00000000 00000000 00000000 00000102 fffffffe
02000403 1c000008 fffffff0 00000001 00000000 00000000 00000000 00000000 00000103 00000001
03000404 1c00000c fffffff0 00000001 00000000 00000000 00000000 00000000 00000104 00000000
04000405 1c000010 f0f0f0f0 0ff00ff0 00000000 00000000 00000000 00000000 00000105 00f000f0
05000406 1c000014 f0f0f0f0 0ff00ff0 00000000 00000000 00000000 00000000 00000106 fff0fff0
06000407 1c000018 f0f0f0f0 0ff00ff0 00000000 00000000 00000000 00000000 00000107 ff00ff00
07000408 1c00001c f0f0f0f0 0ff00ff0 00000000 00000000 00000000 00000000 00000108 000f000f
08000409 1c000020 00000003 00000024 00000000 00000000 00000000 00000000 00000109 00000030
0900040a 1c000024 80000000 0000001f 00000000 00000000 00000000 00000000 0000010a 00000001
0a00040b 1c000028 80000000 00000004 00000000 00000000 00000000 00000000 0000010b f8000000
0b00040c 1c00002c 00000000 00012345 00000000 00000000 00000000 00000000 0000010c 12345000
0c00040d 1c000030 ffffff9c 00000007 00000000 00000000 00000000 00000000 0000010d fffffff2
0e00040e 1c000034 ffffff9c 00000007 00000000 00000000 00000000 00000000 0000010e fffffffe
0d00040f 1c000038 ffffff9c 00000007 00000000 00000000 00000000 00000000 0000010f 24924916
0f000410 1c00003c ffffff9c 00000007 00000000 00000000 00000000 00000000 00000110 00000002
00003100 1c000040 00000100 00000000 11223344 00000000 00000000 00000000 00000000 00000100
00001100 1c000044 00000100 00000001 000000aa 00000000 00000000 00000000 00000000 00000101
00002100 1c000048 00000100 00000002 0000beef 00000000 00000000 00000000 00000000 00000102
00003405 1c00004c 00000100 00000000 00000000 00000000 00000000 00000000 00000105 beefaa44
00001606 1c000050 00000100 00000001 00000000 00000000 00000000 00000000 00000106 ffffffaa
00001407 1c000054 00000100 00000001 00000000 00000000 00000000 00000000 00000107 000000aa
00002608 1c000058 00000100 00000002 00000000 00000000 00000000 00000000 00000108 ffffbeef
00002409 1c00005c 00000100 00000002 00000000 00000000 00000000 00000000 00000109 0000beef
0000160a 1c000060 00000100 00000003 00000000 00000000 00000000 00000000 0000010a ffffffbe
0000240b 1c000064 00000100 00000000 00000000 00000000 00000000 00000000 0000010b 0000aa44
00120000 1c000068 00000005 00000005 00000000 00000040 1c0000a8 00000000 00000000 0000000a
20220000 1c00006c 00000005 00000005 00000000 00000040 1c0000ac 1c000070 00000000 0000000a
10000401 1c000070 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
22300000 1c000074 ffffffff 00000001 00000000 fffffff0 00000000 1c000064 00000000 00000001
10000401 1c000078 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
23620000 1c00007c ffffffff 00000001 00000000 00000020 1c000200 1c00009c 00000000 00000000
10000401 1c000080 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
00730401 1c000084 1c000084 00000004 1c001000 00000008 1c001008 00000000 00000101 1c000088
02400000 1c000088 00000001 00000002 00000000 00000010 00000000 00000000 00000000 00000001
23500000 1c00008c 00000001 00000002 00000000 00000100 00000000 1c00018c 00000000 00000001
10000401 1c000090 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
00003406 1c000094 00000100 00000002 00000000 00000000 00000000 00000000 00091006 00000102
10000401 1c000098 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
10000402 1c00009c 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
40002100 1c0000a0 00000100 00000001 00001234 00000000 00000000 00000000 00091000 00000101
10000401 1c0000a4 00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
40003407 1c0000a8 00000100 00000000 00000000 00000000 00000000 00000000 00000107 beefaa44
00000408 1c0000ac 00000007 00000008 00000000 00000000 00000000 00000000 00000108 0000000f

// ==== verification/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int WORDS   = 10;
    localparam int MAX_PAT = 64;
    localparam int TIMEOUT = 200;

    logic         clk;
    logic         rstn;
    logic         de_valid;
    de_bus_t      de_bus;
    logic         e_allowin;
    logic         ex_en;
    branch_bus_t  branch_bus;
    logic         wb_valid;
    wb_bus_t      wb_bus;
    logic         wb_allowin;

    logic [31:0]  pat_mem [0:MAX_PAT*WORDS-1];
    wb_bus_t      wb_exp_q [$];
    int           wb_idx_q [$];
    branch_bus_t  br_exp_q [$];
    int           br_idx_q [$];
    logic         hold_pending;
    wb_bus_t      held_bus;
    logic         div_in_exec;
    int           n_pat;

    exu_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .de_valid   (de_valid),
        .de_bus     (de_bus),
        .e_allowin  (e_allowin),
        .ex_en      (ex_en),
        .branch_bus (branch_bus),
        .wb_valid   (wb_valid),
        .wb_bus     (wb_bus),
        .wb_allowin (wb_allowin)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure from writeback, roughly one cycle in four
    always @(posedge clk) begin
        #2;
        wb_allowin = ($urandom % 4) != 0;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_wb(input string name, input wb_bus_t exp, input wb_bus_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_branch(input string name, input branch_bus_t exp,
                                  input branch_bus_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic de_bus_t build_de(input int p);
        de_bus_t      d;
        logic [31:0]  ctrl;
        ctrl          = pat_mem[p*WORDS];
        d.pc          = pat_mem[p*WORDS+1];
        d.alu_op      = alu_op_e'(ctrl[27:24]);
        d.src1        = pat_mem[p*WORDS+2];
        d.src2        = pat_mem[p*WORDS+3];
        d.rk_data     = pat_mem[p*WORDS+4];
        d.br_kind     = br_kind_e'(ctrl[22:20]);
        d.jirl        = ctrl[16];
        d.br_offs     = pat_mem[p*WORDS+5];
        d.pred_taken  = ctrl[17];
        d.pred_target = pat_mem[p*WORDS+6];
        d.mem_size    = mem_size_e'(ctrl[13:12]);
        d.mem_store   = ctrl[8];
        d.load_signed = ctrl[9];
        d.gr_we       = ctrl[10];
        d.dest        = ctrl[4:0];
        return d;
    endfunction

    function automatic wb_bus_t expected_wb(input int p);
        wb_bus_t      w;
        logic [31:0]  ctl;
        ctl     = pat_mem[p*WORDS+8];
        w.pc    = pat_mem[p*WORDS+1];
        w.gr_we = ctl[8];
        w.dest  = ctl[4:0];
        w.wdata = pat_mem[p*WORDS+9];
        w.ex    = ctl[12];
        w.ecode = ctl[23:16];
        return w;
    endfunction

    // returns on a negedge once nothing more is expected
    task automatic drain_results();
        int waited;
        waited = 0;
        @(negedge clk);
        while (wb_exp_q.size() != 0 || br_exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("timed out waiting for outstanding results");
            end
            @(negedge clk);
        end
    endtask

    task automatic flush_exception();
        de_valid = 1'b0;
        drain_results();
        @(posedge clk);
        #2;
        ex_en = 1'b1;
        @(posedge clk);
        #2;
        ex_en = 1'b0;
    endtask

    // called a little after a rising edge, returns the same way
    task automatic issue_pattern(input int p);
        logic [31:0]  ctrl;
        alu_op_e      op;
        branch_bus_t  b;
        int           waited;
        ctrl = pat_mem[p*WORDS];
        op   = alu_op_e'(ctrl[27:24]);
        if (ctrl[30]) begin
            flush_exception();
            div_in_exec = 1'b0;
        end
        de_bus   = build_de(p);
        de_valid = 1'b1;
        waited   = 0;
        @(negedge clk);
        while (!e_allowin) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("e_allowin stuck low at pattern %0d", p));
            end
            @(negedge clk);
        end
        // a divide ahead keeps execute closed for its whole iteration
        if (div_in_exec && waited < `EXU_DIV_CYCLES) begin
            fail_run($sformatf("e_allowin rose after %0d cycles behind a divide, pattern %0d",
                               waited, p));
        end
        div_in_exec = !ctrl[28] && (op inside {ALU_DIV, ALU_DIVU, ALU_MOD, ALU_MODU});
        if (!ctrl[28]) begin
            wb_exp_q.push_back(expected_wb(p));
            wb_idx_q.push_back(p);
        end
        if (ctrl[29]) begin
            b.redirect = 1'b1;
            b.target   = pat_mem[p*WORDS+7];
            br_exp_q.push_back(b);
            br_idx_q.push_back(p);
        end
        @(posedge clk);
        #2;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (hold_pending) begin
                if (!wb_valid) begin
                    fail_run("wb_valid dropped while wb_allowin was low");
                end else begin
                    compare_wb("held wb_bus", held_bus, wb_bus);
                end
            end
            hold_pending = wb_valid && !wb_allowin;
            held_bus     = wb_bus;

            if (branch_bus.redirect) begin
                if (br_exp_q.size() == 0) begin
                    fail_run("redirect raised for a correctly predicted branch");
                end else begin
                    compare_branch($sformatf("branch pattern %0d", br_idx_q.pop_front()),
                                   br_exp_q.pop_front(), branch_bus);
                end
            end

            if (wb_valid && wb_allowin) begin
                if (wb_exp_q.size() == 0) begin
                    fail_run("writeback result arrived with none expected");
                end else begin
                    compare_wb($sformatf("pattern %0d", wb_idx_q.pop_front()),
                               wb_exp_q.pop_front(), wb_bus);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h4e2611eb));
        rstn         = 1'b0;
        de_valid     = 1'b0;
        de_bus       = '0;
        ex_en        = 1'b0;
        wb_allowin   = 1'b0;
        hold_pending = 1'b0;
        held_bus     = '0;
        div_in_exec  = 1'b0;

        // unread rows keep an address-tagged fill, which marks the end
        for (int i = 0; i < MAX_PAT*WORDS; i++) begin
            pat_mem[i] = 32'hdead0000 | i;
        end
        $readmemh("verification/exu_patterns.hex", pat_mem);
        n_pat = 0;
        while (n_pat < MAX_PAT && pat_mem[n_pat*WORDS] != (32'hdead0000 | (n_pat*WORDS))) begin
            n_pat++;
        end

        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;

        for (int p = 0; p < n_pat; p++) begin
            issue_pattern(p);
        end
        de_valid = 1'b0;
        drain_results();

        if (n_pat > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("pattern file holds no instructions");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  de_valid,
    input  exu_pkg::de_bus_t      de_bus,
    output logic                  e_allowin,
    input  logic                  ex_en,
    output exu_pkg::branch_bus_t  branch_bus,
    output logic                  wb_valid,
    output exu_pkg::wb_bus_t      wb_bus,
    input  logic                  wb_allowin
);
    import exu_pkg::*;

    logic         em_valid;
    em_bus_t      em_bus;
    logic         m_allowin;
    logic         ram_en;
    logic [3:0]   ram_we;
    logic [31:0]  ram_addr;
    logic [31:0]  ram_wdata;
    logic [31:0]  ram_rdata;

    exu_execute_stage u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .de_valid   (de_valid),
        .de_bus     (de_bus),
        .e_allowin  (e_allowin),
        .em_valid   (em_valid),
        .em_bus     (em_bus),
        .m_allowin  (m_allowin),
        .ex_en      (ex_en),
        .branch_bus (branch_bus),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    exu_data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    exu_mem_stage u_mem (
        .clk        (clk),
        .rstn       (rstn),
        .em_valid   (em_valid),
        .em_bus     (em_bus),
        .m_allowin  (m_allowin),
        .ram_rdata  (ram_rdata),
        .wb_valid   (wb_valid),
        .wb_bus     (wb_bus),
        .wb_allowin (wb_allowin)
    );

endmodule

`default_nettype wire

// ==== hdl/exu_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_mem_stage (
    input  logic              clk,
    input  logic              rstn,
    input  logic              em_valid,
    input  exu_pkg::em_bus_t  em_bus,
    output logic              m_allowin,
    input  logic [31:0]       ram_rdata,
    output logic              wb_valid,
    output exu_pkg::wb_bus_t  wb_bus,
    input  logic              wb_allowin
);
    import exu_pkg::*;

    em_bus_t      em_r;
    logic         m_valid;
    logic         m_first;
    logic [31:0]  rdata_hold;
    logic [31:0]  load_word;
    logic [31:0]  shifted;
    logic [31:0]  load_data;

    assign m_allowin = !m_valid || wb_allowin;
    assign wb_valid  = m_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_valid <= 1'b0;
            m_first <= 1'b0;
        end else if (m_allowin) begin
            m_valid <= em_valid;
            m_first <= em_valid;
        end else begin
            m_first <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (em_valid && m_allowin) begin
            em_r <= em_bus;
        end
        if (m_first) begin
            rdata_hold <= ram_rdata;
        end
    end

    // ram output is only fresh in the first occupied cycle
    assign load_word = m_first ? ram_rdata : rdata_hold;
    assign shifted   = load_word >> {em_r.result[1:0], 3'b000};

    always_comb begin
        case (em_r.mem_size)
            MEM_BYTE: load_data = {{24{em_r.load_signed && shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_data = {{16{em_r.load_signed && shifted[15]}}, shifted[15:0]};
            default:  load_data = shifted;
        endcase
    end

    // a faulting access reports its address and writes no register
    always_comb begin
        wb_bus.pc    = em_r.pc;
        wb_bus.gr_we = em_r.gr_we && !em_r.ex;
        wb_bus.dest  = em_r.dest;
        wb_bus.wdata = (em_r.load && !em_r.ex) ? load_data : em_r.result;
        wb_bus.ex    = em_r.ex;
        wb_bus.ecode = em_r.ecode;
    end

endmodule

`default_nettype wire

// ==== hdl/exu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_data_ram (
    input  logic        clk,
    input  logic        en,
    input  logic [3:0]  we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int ADDR_W = $clog2(`EXU_RAM_WORDS);

    logic [31:0]        mem [0:`EXU_RAM_WORDS-1];
    logic [ADDR_W-1:0]  idx;

    // word index, byte offset dropped
    assign idx = addr[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            // read returns the word as it was before this write
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exu_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_execute_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  de_valid,
    input  exu_pkg::de_bus_t      de_bus,
    output logic                  e_allowin,
    output logic                  em_valid,
    output exu_pkg::em_bus_t      em_bus,
    input  logic                  m_allowin,
    input  logic                  ex_en,
    output exu_pkg::branch_bus_t  branch_bus,
    output logic                  ram_en,
    output logic [3:0]            ram_we,
    output logic [31:0]           ram_addr,
    output logic [31:0]           ram_wdata
);
    import exu_pkg::*;

    de_bus_t      de_r;
    logic         e_valid;
    logic         e_fresh;
    logic         ex_flag;
    logic         e_go;
    logic         e_accept;
    logic         stall;
    logic [31:0]  alu_result;
    logic         is_mem;
    logic         ale;
    logic         ex_e;
    logic [3:0]   lane_we;
    logic         br_eq;
    logic         br_lt;
    logic         br_taken;
    logic [31:0]  br_target;
    logic         mispredict;

    assign e_allowin = (!e_valid || m_allowin) && !stall;
    assign em_valid  = e_valid && !stall;
    assign e_go      = em_valid && m_allowin;

    // squash what arrives behind a fault or a mispredict
    assign e_accept = de_valid && !ex_flag && !ex_e && !ex_en && !branch_bus.redirect;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            e_valid <= 1'b0;
            e_fresh <= 1'b0;
        end else if (ex_en) begin
            e_valid <= 1'b0;
            e_fresh <= 1'b0;
        end else if (e_allowin) begin
            e_valid <= e_accept;
            e_fresh <= e_accept;
        end else begin
            e_fresh <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (de_valid && e_allowin) begin
            de_r <= de_bus;
        end
    end

    exu_alu u_alu (
        .clk    (clk),
        .rstn   (rstn),
        .alu_op (de_r.alu_op),
        .src1   (de_r.src1),
        .src2   (de_r.src2),
        .start  (e_valid && e_fresh),
        .result (alu_result),
        .stall  (stall)
    );

    // blt/bge decode to slt, bltu/bgeu to sltu
    assign br_eq     = de_r.src1 == de_r.src2;
    assign br_lt     = alu_result[0];
    assign br_target = (de_r.jirl ? de_r.rk_data : de_r.pc) + de_r.br_offs;

    always_comb begin
        case (de_r.br_kind)
            BR_BEQ:  br_taken = br_eq;
            BR_BNE:  br_taken = !br_eq;
            BR_BLT:  br_taken = br_lt;
            BR_BGE:  br_taken = !br_lt;
            BR_BLTU: br_taken = br_lt;
            BR_BGEU: br_taken = !br_lt;
            BR_JUMP: br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    assign mispredict = e_valid && ((br_taken != de_r.pred_taken) ||
                        (br_taken && de_r.pred_taken && br_target != de_r.pred_target));

    // one redirect per branch, on its way out
    assign branch_bus.redirect = e_go && mispredict;
    assign branch_bus.target   = br_taken ? br_target : de_r.pc + 32'd4;

    assign is_mem = de_r.mem_size != MEM_NONE;
    assign ex_e   = e_valid && ale;

    always_comb begin
        case (de_r.mem_size)
            MEM_BYTE: begin
                ale     = 1'b0;
                lane_we = 4'b0001 << alu_result[1:0];
            end
            MEM_HALF: begin
                ale     = alu_result[0];
                lane_we = alu_result[1] ? 4'b1100 : 4'b0011;
            end
            MEM_WORD: begin
                ale     = |alu_result[1:0];
                lane_we = 4'b1111;
            end
            default: begin
                ale     = 1'b0;
                lane_we = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_flag <= 1'b0;
        end else if (ex_en) begin
            ex_flag <= 1'b0;
        end else if (ex_e) begin
            ex_flag <= 1'b1;
        end
    end

    assign ram_en   = e_go && is_mem && !ale;
    assign ram_we   = (ram_en && de_r.mem_store) ? lane_we : 4'b0000;
    assign ram_addr = alu_result;

    always_comb begin
        case (de_r.mem_size)
            MEM_BYTE: ram_wdata = {4{de_r.rk_data[7:0]}};
            MEM_HALF: ram_wdata = {2{de_r.rk_data[15:0]}};
            default:  ram_wdata = de_r.rk_data;
        endcase
    end

    always_comb begin
        em_bus.pc          = de_r.pc;
        em_bus.result      = alu_result;
        em_bus.gr_we       = de_r.gr_we;
        em_bus.dest        = de_r.dest;
        em_bus.mem_size    = de_r.mem_size;
        em_bus.load        = is_mem && !de_r.mem_store;
        em_bus.load_signed = de_r.load_signed;
        em_bus.ex          = ex_e;
        em_bus.ecode       = ale ? `EXU_ECODE_ALE : 8'h00;
    end

endmodule

`default_nettype wire

// ==== hdl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_alu (
    input  logic              clk,
    input  logic              rstn,
    input  exu_pkg::alu_op_e  alu_op,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    input  logic              start,
    output logic [31:0]       result,
    output logic              stall
);
    import exu_pkg::*;

    localparam int CNT_W = $clog2(`EXU_DIV_CYCLES) + 1;

    logic              is_div;
    logic              is_signed;
    logic              a_neg;
    logic              b_neg;
    logic [31:0]       abs_a;
    logic [31:0]       abs_b;
    logic              div_go;
    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic [31:0]       rem_r;
    logic [31:0]       quo_r;
    logic [31:0]       dvs_r;
    logic              q_neg;
    logic              r_neg;
    logic [63:0]       first_step;
    logic [63:0]       next_step;

    // one restoring shift-subtract step, returns {rem, quo}
    function automatic logic [63:0] div_step(input logic [31:0] rem_in,
                                             input logic [31:0] quo_in,
                                             input logic [31:0] dvs);
        logic [32:0] shifted;
        logic [32:0] diff;
        shifted = {rem_in, quo_in[31]};
        diff = shifted - {1'b0, dvs};
        if (diff[32]) begin
            div_step = {shifted[31:0], quo_in[30:0], 1'b0};
        end else begin
            div_step = {diff[31:0], quo_in[30:0], 1'b1};
        end
    endfunction

    assign is_div    = alu_op inside {ALU_DIV, ALU_DIVU, ALU_MOD, ALU_MODU};
    assign is_signed = alu_op inside {ALU_DIV, ALU_MOD};
    assign a_neg     = is_signed && src1[31];
    assign b_neg     = is_signed && src2[31];
    assign abs_a     = a_neg ? -src1 : src1;
    assign abs_b     = b_neg ? -src2 : src2;

    // first quotient bit is taken on the start edge
    assign div_go     = start && is_div && !busy;
    assign first_step = div_step(32'd0, abs_a, abs_b);
    assign next_step  = div_step(rem_r, quo_r, dvs_r);
    assign stall      = (start && is_div) || busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (div_go) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(1);
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(`EXU_DIV_CYCLES - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_go) begin
            {rem_r, quo_r} <= first_step;
            dvs_r          <= abs_b;
            q_neg          <= a_neg ^ b_neg;
            r_neg          <= a_neg;
        end else if (busy) begin
            {rem_r, quo_r} <= next_step;
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:   result = src1 + src2;
            ALU_SUB:   result = src1 - src2;
            ALU_SLT:   result = {31'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU:  result = {31'd0, src1 < src2};
            ALU_AND:   result = src1 & src2;
            ALU_OR:    result = src1 | src2;
            ALU_XOR:   result = src1 ^ src2;
            ALU_NOR:   result = ~(src1 | src2);
            ALU_SLL:   result = src1 << src2[4:0];
            ALU_SRL:   result = src1 >> src2[4:0];
            ALU_SRA:   result = $unsigned($signed(src1) >>> src2[4:0]);
            ALU_LU12I: result = {src2[19:0], 12'd0};
            ALU_DIV:   result = q_neg ? -quo_r : quo_r;
            ALU_DIVU:  result = quo_r;
            ALU_MOD:   result = r_neg ? -rem_r : rem_r;
            ALU_MODU:  result = rem_r;
            default:   result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exu_pkg.sv ====
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LU12I,
        ALU_DIV, ALU_DIVU, ALU_MOD, ALU_MODU
    } alu_op_e;

    // BR_JUMP covers b, bl and jirl
    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
    } br_kind_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] pc;
        alu_op_e              alu_op;
        logic [`EXU_XLEN-1:0] src1;
        logic [`EXU_XLEN-1:0] src2;
        logic [`EXU_XLEN-1:0] rk_data;
        br_kind_e             br_kind;
        logic                 jirl;
        logic [`EXU_XLEN-1:0] br_offs;
        logic                 pred_taken;
        logic [`EXU_XLEN-1:0] pred_target;
        mem_size_e            mem_size;
        logic                 mem_store;
        logic                 load_signed;
        logic                 gr_we;
        logic [4:0]           dest;
    } de_bus_t;

    // result doubles as the memory address
    typedef struct packed {
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] result;
        logic                 gr_we;
        logic [4:0]           dest;
        mem_size_e            mem_size;
        logic                 load;
        logic                 load_signed;
        logic                 ex;
        logic [7:0]           ecode;
    } em_bus_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] pc;
        logic                 gr_we;
        logic [4:0]           dest;
        logic [`EXU_XLEN-1:0] wdata;
        logic                 ex;
        logic [7:0]           ecode;
    } wb_bus_t;

    typedef struct packed {
        logic                 redirect;
        logic [`EXU_XLEN-1:0] target;
    } branch_bus_t;

endpackage

`default_nettype wire

// ==== hdl/exu_cfg.svh ====
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data path width
`define EXU_XLEN 32

// data RAM depth in 32-bit words
`define EXU_RAM_WORDS 256

// restoring divider, one quotient bit per cycle
`define EXU_DIV_CYCLES 32

// address misaligned exception code
`define EXU_ECODE_ALE 8'h09

`endif
